/* tb/adc_if_stim.txt */
// mode (0 one lane, 1 two lanes)  period in cycles  18-bit sample, all hex
// a line with mode F marks the end of the list
0 0018 2A5C3
0 0019 3FFFF
0 0020 00000
0 0010 20000
0 0030 00001
0 0024 15555
0 001C 2AAAA
0 0040 0F0F0
1 0018 1FF00
1 0018 000FF
1 0022 3FE01
1 0010 2A955
1 0028 00000
1 001A 3FFFF
1 0030 12345
1 0040 30C0F
0 0021 1B6DB
1 0019 24924
F FFFF FFFFF

/* sources.f */
+incdir+source
source/adc_if_pkg.sv
source/adc_ctrl_if.sv
source/adc_if_regs.sv
source/adc_cnv_timing.sv
source/adc_lane_capture.sv
source/adc_if_top.sv
tb/adc_if_tb.sv

/* Bender.yml */
package:
  name: adc_if

export_include_dirs:
  - source

sources:
  - files:
      - source/adc_if_pkg.sv
      - source/adc_ctrl_if.sv
      - source/adc_if_regs.sv
      - source/adc_cnv_timing.sv
      - source/adc_lane_capture.sv
      - source/adc_if_top.sv
  - target: test
    files:
      - tb/adc_if_tb.sv

/* tb/adc_if_tb.sv */
// ****************************************
// testbench for the SAR ADC front end
// drives APB and an ADC lane model from the stim file,
// checks register access, capture data, timing and overrun counting
// ****************************************

`timescale 1ns/1ps

`include "adc_if_config.svh"

module adc_if_tb;

  localparam int CLK_PERIOD = 100;
  localparam int MAX_LINES  = 64;
  localparam int OVR_CONVS  = 10;

  logic                       s_axi_aclk;
  logic                       arst_n;
  logic [3:0]                 paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [31:0]                pwdata;
  logic [31:0]                prdata;
  logic                       pready;
  logic                       pslverr;
  logic                       cnv;
  logic                       clk_gate;
  logic                       da;
  logic                       db;
  logic                       adc_valid;
  logic [`ADC_RESOLUTION-1:0] adc_data;

  // each stim line gives three hex fields in the order mode, period and sample
  logic [19:0]                stim_mem [0:3*MAX_LINES-1];
  integer                     seed;
  int                         error_count = 0;
  int                         watch_limit = 0;
  int                         cycle = 0;
  int                         run_id = 0;
  int                         exp_period = `ADC_MIN_PERIOD;
  int                         exp_gate = `ADC_RESOLUTION;
  // ADC model state
  logic                       model_two = 1'b0;
  logic [`ADC_RESOLUTION-1:0] model_value = '0;
  logic [`ADC_RESOLUTION-1:0] shift_word = '0;
  int                         bit_idx = 0;
  // timing monitor state
  int                         last_cnv_cycle = 0;
  int                         last_cnv_run = -1;
  int                         gate_cycles = 0;

  adc_if_top DUT (
    .s_axi_aclk (s_axi_aclk),
    .arst_n     (arst_n),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .cnv        (cnv),
    .clk_gate   (clk_gate),
    .da         (da),
    .db         (db),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data)
  );

  initial begin
    s_axi_aclk = 1'b0;
    forever #(CLK_PERIOD/2) s_axi_aclk = ~s_axi_aclk;
  end

  always @(posedge s_axi_aclk) begin
    cycle <= cycle + 1;
  end

  // ****************************************
  // reporting and APB tasks
  // ****************************************

  task automatic abort_run(input string why);
    error_count++;
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // only the four documented offsets answer without an error
  function automatic logic is_mapped(input logic [3:0] addr);
    return (addr == `REG_CTRL) || (addr == `REG_PERIOD) ||
           (addr == `REG_SAMPLE) || (addr == `REG_STATUS);
  endfunction

  // every task here starts and ends 1 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic err_exp;
    err_exp = !is_mapped(addr);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge s_axi_aclk);
    #1;
    penable = 1'b1;
    // response is looked at in the middle of the access phase
    #(CLK_PERIOD/2);
    rdata = prdata;
    check_value("pready", pready, 32'd1);
    check_value("pslverr", pslverr, err_exp);
    @(posedge s_axi_aclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'd0, data);
  endtask

  task automatic read_expect(input string name, input logic [3:0] addr,
                             input logic [31:0] exp);
    logic [31:0] got;
    apb_read(addr, got);
    check_value(name, got, exp);
  endtask

  // waits at least one edge so a valid already seen is not counted twice
  task automatic wait_sample(input logic [`ADC_RESOLUTION-1:0] exp_val);
    int waited;
    waited = 0;
    do begin
      @(posedge s_axi_aclk);
      #1;
      waited++;
      if (waited > 4 * exp_period + 64) begin
        abort_run("no adc_valid arrived after the conversion was started");
      end
    end while (adc_valid !== 1'b1);
    check_value("adc_data", adc_data, exp_val);
  endtask

  // ****************************************
  // ADC lane model
  // ****************************************

  // loads the value at cnv and puts one bit out per gated cycle, MSB first
  always @(posedge s_axi_aclk) begin
    #1;
    if (cnv === 1'b1) begin
      shift_word = model_value;
      bit_idx    = 0;
    end
    if (clk_gate === 1'b1) begin
      if (model_two) begin
        // lane a takes the upper half and lane b the lower half
        da = shift_word[`ADC_RESOLUTION-1-bit_idx];
        db = shift_word[`ADC_LANE_BITS-1-bit_idx];
      end else begin
        da = shift_word[`ADC_RESOLUTION-1-bit_idx];
      end
      bit_idx++;
    end
  end

  // ****************************************
  // timing monitor
  // ****************************************

  // looks at the outputs mid-cycle where they are settled
  always @(negedge s_axi_aclk) begin
    if (arst_n === 1'b1) begin
      if (cnv === 1'b1) begin
        // pulses from an earlier run are never compared with this one
        if (last_cnv_run == run_id) begin
          check_value("cnv spacing", cycle - last_cnv_cycle, exp_period);
        end
        last_cnv_cycle = cycle;
        last_cnv_run   = run_id;
      end
      if (clk_gate === 1'b1) begin
        gate_cycles++;
      end else if (gate_cycles != 0) begin
        check_value("clk_gate window length", gate_cycles, exp_gate);
        gate_cycles = 0;
      end
      if (adc_valid === 1'b1) begin
        check_value("cnv to adc_valid latency", cycle - last_cnv_cycle,
                    `ADC_CONV_DELAY + exp_gate + 1);
      end
    end
  end

  // ****************************************
  // test sequences
  // ****************************************

  // runs two back to back conversions of one stim line and reads the sample back
  task automatic run_line(input logic mode, input logic [15:0] per,
                          input logic [`ADC_RESOLUTION-1:0] val);
    logic [31:0] status;
    exp_period  = (per < `ADC_MIN_PERIOD) ? `ADC_MIN_PERIOD : per;
    exp_gate    = mode ? `ADC_LANE_BITS : `ADC_RESOLUTION;
    model_two   = mode;
    model_value = val;
    run_id++;
    apb_write(`REG_PERIOD, {16'd0, per});
    read_expect("period register", `REG_PERIOD, exp_period);
    apb_write(`REG_CTRL, {30'd0, mode, 1'b1});
    wait_sample(val);
    wait_sample(val);
    apb_write(`REG_CTRL, {30'd0, mode, 1'b0});
    apb_read(`REG_STATUS, status);
    check_value("status new-sample bit", status[8], 32'd1);
    read_expect("sample register", `REG_SAMPLE, {14'd0, val});
    apb_read(`REG_STATUS, status);
    check_value("status new-sample bit", status[8], 32'd0);
  endtask

  // unread samples pile up and each one after the first counts as an overrun
  task automatic overrun_test();
    logic [31:0]                status;
    logic [`ADC_RESOLUTION-1:0] next_val;
    int                         i;
    apb_write(`REG_STATUS, 32'd1);
    apb_read(`REG_STATUS, status);
    check_value("overrun count", status[23:16], 32'd0);
    exp_period = `ADC_MIN_PERIOD;
    exp_gate   = `ADC_RESOLUTION;
    model_two  = 1'b0;
    run_id++;
    next_val    = $random(seed);
    model_value = next_val;
    apb_write(`REG_PERIOD, `ADC_MIN_PERIOD);
    apb_write(`REG_CTRL, 32'd1);
    for (i = 0; i < OVR_CONVS; i++) begin
      wait_sample(next_val);
      next_val    = $random(seed);
      model_value = next_val;
    end
    apb_write(`REG_CTRL, 32'd0);
    apb_read(`REG_STATUS, status);
    check_value("overrun count", status[23:16], (OVR_CONVS - 1 > 255) ? 255 : OVR_CONVS - 1);
    check_value("status new-sample bit", status[8], 32'd1);
    apb_write(`REG_STATUS, 32'd1);
    apb_read(`REG_STATUS, status);
    check_value("overrun count", status[23:16], 32'd0);
  endtask

  initial begin
    int num_lines;
    int per_sum;
    int per;
    int k;
    seed    = 22831;
    arst_n  = 1'b0;
    paddr   = 4'h0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = 32'd0;
    da      = 1'b0;
    db      = 1'b0;
    $readmemh("tb/adc_if_stim.txt", stim_mem);
    // a mode field of F closes the list
    num_lines = 0;
    per_sum   = 0;
    while (num_lines < MAX_LINES && stim_mem[3*num_lines] !== 20'hF) begin
      if ($isunknown(stim_mem[3*num_lines])) begin
        abort_run("stim file is missing or has no end line");
      end
      per       = stim_mem[3*num_lines+1][15:0];
      per_sum  += (per < `ADC_MIN_PERIOD) ? `ADC_MIN_PERIOD : per;
      num_lines++;
    end
    assert (num_lines > 0) else begin
      abort_run("stim file holds no conversions");
    end
    watch_limit = per_sum * 4 + 2000;

    repeat (5) @(posedge s_axi_aclk);
    #1;
    arst_n = 1'b1;

    // the converter stays idle right after reset
    repeat (8) begin
      @(posedge s_axi_aclk);
      #1;
      check_value("cnv", cnv, 32'd0);
      check_value("clk_gate", clk_gate, 32'd0);
      check_value("adc_valid", adc_valid, 32'd0);
    end
    read_expect("period register", `REG_PERIOD, `ADC_MIN_PERIOD);
    read_expect("control register", `REG_CTRL, 32'd0);
    read_expect("status register", `REG_STATUS, 32'd0);

    // register access with clamping and unmapped offsets
    apb_write(`REG_CTRL, 32'd2);
    read_expect("control register", `REG_CTRL, 32'd2);
    apb_write(`REG_CTRL, 32'd0);
    read_expect("control register", `REG_CTRL, 32'd0);
    apb_write(`REG_PERIOD, 32'h0123);
    read_expect("period register", `REG_PERIOD, 32'h0123);
    apb_write(`REG_PERIOD, 32'd5);
    read_expect("period register", `REG_PERIOD, `ADC_MIN_PERIOD);
    apb_write(`REG_PERIOD, 32'd0);
    read_expect("period register", `REG_PERIOD, `ADC_MIN_PERIOD);
    read_expect("unmapped read data", 4'h2, 32'd0);
    read_expect("unmapped read data", 4'h6, 32'd0);
    apb_write(4'hE, 32'hFFFF_FFFF);
    read_expect("control register", `REG_CTRL, 32'd0);

    // capture in both lane modes with timing watched by the monitor
    for (k = 0; k < num_lines; k++) begin
      run_line(stim_mem[3*k][0], stim_mem[3*k+1][15:0],
               stim_mem[3*k+2][`ADC_RESOLUTION-1:0]);
    end

    overrun_test();

    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // bounds the run by the total conversion time of the stim file
  initial begin
    wait (watch_limit > 0);
    repeat (watch_limit) @(posedge s_axi_aclk);
    abort_run($sformatf("watchdog expired after %0d cycles", watch_limit));
  end

endmodule

/* source/adc_if_top.sv */
// ****************************************
// top level of the SAR ADC front end
// APB registers, conversion timer and lane capture on one clock
// ****************************************

`timescale 1ns/1ps

`include "adc_if_config.svh"

module adc_if_top (
  input  logic                       s_axi_aclk,
  input  logic                       arst_n,
  // APB slave
  input  logic [3:0]                 paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  // converter pins
  output logic                       cnv,
  output logic                       clk_gate,
  input  logic                       da,
  input  logic                       db,
  // sample stream without back-pressure
  output logic                       adc_valid,
  output logic [`ADC_RESOLUTION-1:0] adc_data
);

  logic gate_open;
  logic last_bit;

  // control settings shared by all three blocks
  adc_ctrl_if ctrl_bus ();

  adc_if_regs i_regs (
    .s_axi_aclk   (s_axi_aclk),
    .arst_n       (arst_n),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .sample_valid (adc_valid),
    .sample_data  (adc_data),
    .ctrl         (ctrl_bus.regs)
  );

  adc_cnv_timing i_timing (
    .s_axi_aclk (s_axi_aclk),
    .arst_n     (arst_n),
    .ctrl       (ctrl_bus.timer),
    .cnv        (cnv),
    .clk_gate   (clk_gate),
    .gate_open  (gate_open),
    .last_bit   (last_bit)
  );

  // finished samples go both to the outputs and to the readback register
  adc_lane_capture i_capture (
    .s_axi_aclk   (s_axi_aclk),
    .arst_n       (arst_n),
    .da           (da),
    .db           (db),
    .gate_open    (gate_open),
    .last_bit     (last_bit),
    .ctrl         (ctrl_bus.capture),
    .sample_valid (adc_valid),
    .sample_data  (adc_data)
  );

endmodule

/* source/adc_lane_capture.sv */
// ****************************************
// serial lane capture of the ADC front end
// shifts one or two lanes in MSB first and emits one sample per window
// ****************************************

`timescale 1ns/1ps

`include "adc_if_config.svh"

module adc_lane_capture
  import adc_if_pkg::*;
(
  input  logic                       s_axi_aclk,
  input  logic                       arst_n,
  input  logic                       da,
  input  logic                       db,
  input  logic                       gate_open,
  input  logic                       last_bit,
  adc_ctrl_if.capture                ctrl,
  output logic                       sample_valid,
  output logic [`ADC_RESOLUTION-1:0] sample_data
);

  adc_word_u shift_q;
  logic      last_q;

  // ****************************************
  // shifter
  // ****************************************

  // one-lane mode fills the whole word from da,
  // two-lane mode fills both halves side by side
  always_ff @(posedge s_axi_aclk) begin
    if (gate_open) begin
      if (ctrl.two_lanes) begin
        shift_q.lanes.lane_a <= {shift_q.lanes.lane_a[`ADC_LANE_BITS-2:0], da};
        shift_q.lanes.lane_b <= {shift_q.lanes.lane_b[`ADC_LANE_BITS-2:0], db};
      end else begin
        shift_q.word <= {shift_q.word[`ADC_RESOLUTION-2:0], da};
      end
    end
  end

  // ****************************************
  // sample output
  // ****************************************

  // the last bit lands in the shifter on the last_bit edge,
  // so the word is complete one cycle later
  always_ff @(posedge s_axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      last_q       <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      last_q       <= last_bit;
      sample_valid <= last_q;
    end
  end

  // sample data holds until the next window completes
  always_ff @(posedge s_axi_aclk) begin
    if (last_q) begin
      sample_data <= shift_q.word;
    end
  end

  // a sample is only ever produced by a window that the timer opened
  assert property (@(posedge s_axi_aclk) disable iff (!arst_n)
    sample_valid |-> $past(gate_open, 2));

endmodule

/* source/adc_cnv_timing.sv */
// ****************************************
// conversion timer of the ADC front end
// fires cnv once per period and then opens the bit clock gate
// ****************************************

`timescale 1ns/1ps

`include "adc_if_config.svh"

module adc_cnv_timing (
  input  logic       s_axi_aclk,
  input  logic       arst_n,
  adc_ctrl_if.timer  ctrl,
  output logic       cnv,
  output logic       clk_gate,
  output logic       gate_open,
  output logic       last_bit
);

  localparam int DELAY_W = $clog2(`ADC_CONV_DELAY + 1);

  logic [15:0]               period_cnt;
  logic [DELAY_W-1:0]        delay_cnt;
  logic [`ADC_GATE_BITS-1:0] gate_cnt;
  logic                      fire;

  // ****************************************
  // period counter
  // ****************************************

  // counter sits at zero while disabled so the first pulse follows enable at once
  assign fire = ctrl.enable && (period_cnt == 16'd0);

  always_ff @(posedge s_axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= 16'd0;
      cnv        <= 1'b0;
    end else begin
      cnv <= fire;
      if (!ctrl.enable) begin
        period_cnt <= 16'd0;
      end else if (fire) begin
        // the period is sampled here, so a new value applies from the next pulse on
        period_cnt <= ctrl.period - 16'd1;
      end else begin
        period_cnt <= period_cnt - 16'd1;
      end
    end
  end

  // ****************************************
  // delay and gate window
  // ****************************************

  // the window runs to its end even if enable drops meanwhile
  always_ff @(posedge s_axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      delay_cnt <= '0;
      gate_cnt  <= '0;
      clk_gate  <= 1'b0;
    end else begin
      if (fire) begin
        delay_cnt <= DELAY_W'(`ADC_CONV_DELAY);
      end else if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - DELAY_W'(1);
      end
      if (delay_cnt == DELAY_W'(1)) begin
        clk_gate <= 1'b1;
        gate_cnt <= ctrl.gate_len - `ADC_GATE_BITS'(1);
      end else if (clk_gate) begin
        if (gate_cnt == '0) begin
          clk_gate <= 1'b0;
        end else begin
          gate_cnt <= gate_cnt - `ADC_GATE_BITS'(1);
        end
      end
    end
  end

  assign gate_open = clk_gate;
  // marks the final gated cycle of the window
  assign last_bit  = clk_gate && (gate_cnt == '0);

  // the converter must be idle before its output is clocked out
  assert property (@(posedge s_axi_aclk) disable iff (!arst_n)
    !(cnv && clk_gate));

endmodule

/* source/adc_if_regs.sv */
// ****************************************
// APB register bank of the ADC front end
// holds control and period, reads back the latest sample,
// and counts samples that were overwritten before being read
// ****************************************

`timescale 1ns/1ps

`include "adc_if_config.svh"

module adc_if_regs
  import adc_if_pkg::*;
(
  input  logic                       s_axi_aclk,
  input  logic                       arst_n,
  input  logic [3:0]                 paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  logic                       sample_valid,
  input  logic [`ADC_RESOLUTION-1:0] sample_data,
  adc_ctrl_if.regs                   ctrl
);

  adc_reg_e                   reg_sel;
  logic                       access;
  logic                       wr_en;
  logic                       rd_en;
  logic                       mapped;
  logic [31:0]                rd_data;
  logic [15:0]                period_wr;
  logic                       enable_q;
  logic                       two_lanes_q;
  logic [15:0]                period_q;
  logic [`ADC_RESOLUTION-1:0] sample_q;
  logic                       new_flag;
  logic [7:0]                 ovr_cnt;
  logic                       sample_rd;
  logic                       ovr_clr;

  // ****************************************
  // APB decode
  // ****************************************

  // every transfer completes in its access phase, no wait states
  assign pready = 1'b1;

  assign reg_sel = adc_reg_e'(paddr);
  assign access  = psel && penable;
  assign wr_en   = access && pwrite && mapped;
  assign rd_en   = access && !pwrite && mapped;

  // read mux, offsets outside the map decode as unmapped
  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (reg_sel)
      ADDR_CTRL:   rd_data = {30'd0, two_lanes_q, enable_q};
      ADDR_PERIOD: rd_data = {16'd0, period_q};
      ADDR_SAMPLE: rd_data = {{(32-`ADC_RESOLUTION){1'b0}}, sample_q};
      ADDR_STATUS: rd_data = {8'd0, ovr_cnt, 7'd0, new_flag, 8'd0};
      default:     mapped  = 1'b0;
    endcase
  end

  // an unmapped access answers with an error and zero data
  assign prdata  = (access && !pwrite) ? rd_data : 32'd0;
  assign pslverr = access && !mapped;

  // ****************************************
  // control and period registers
  // ****************************************

  // short periods would let the bit window overlap the next conversion
  assign period_wr = (pwdata[15:0] < 16'(`ADC_MIN_PERIOD)) ?
                     16'(`ADC_MIN_PERIOD) : pwdata[15:0];

  always_ff @(posedge s_axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      enable_q    <= 1'b0;
      two_lanes_q <= 1'b0;
      period_q    <= 16'(`ADC_MIN_PERIOD);
    end else if (wr_en) begin
      if (reg_sel == ADDR_CTRL) begin
        enable_q    <= pwdata[0];
        two_lanes_q <= pwdata[1];
      end
      if (reg_sel == ADDR_PERIOD) begin
        period_q <= period_wr;
      end
    end
  end

  assign ctrl.enable    = enable_q;
  assign ctrl.two_lanes = two_lanes_q;
  assign ctrl.period    = period_q;
  // window length is decided here once so the receivers never look at the lane mode for it
  assign ctrl.gate_len  = two_lanes_q ? `ADC_GATE_BITS'(`ADC_LANE_BITS) :
                                        `ADC_GATE_BITS'(`ADC_RESOLUTION);

  // ****************************************
  // sample readback and overrun status
  // ****************************************

  assign sample_rd = rd_en && (reg_sel == ADDR_SAMPLE);
  assign ovr_clr   = wr_en && (reg_sel == ADDR_STATUS) && pwdata[0];

  // latest sample is simply overwritten, there is no back-pressure
  always_ff @(posedge s_axi_aclk) begin
    if (sample_valid) begin
      sample_q <= sample_data;
    end
  end

  always_ff @(posedge s_axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      new_flag <= 1'b0;
      ovr_cnt  <= 8'd0;
    end else begin
      // a new sample wins over a read in the same cycle
      if (sample_valid) begin
        new_flag <= 1'b1;
      end else if (sample_rd) begin
        new_flag <= 1'b0;
      end
      // a pending sample that is read in the same cycle is not lost
      if (ovr_clr) begin
        ovr_cnt <= 8'd0;
      end else if (sample_valid && new_flag && !sample_rd && (ovr_cnt != 8'hFF)) begin
        ovr_cnt <= ovr_cnt + 8'd1;
      end
    end
  end

  // ****************************************
  // assertions
  // ****************************************

  // the access phase must belong to a selected transfer
  assert property (@(posedge s_axi_aclk) disable iff (!arst_n)
    $rose(penable) |-> psel);

  // timer relies on this to keep windows apart
  assert property (@(posedge s_axi_aclk) disable iff (!arst_n)
    ctrl.period >= 16'(`ADC_MIN_PERIOD));

endmodule

/* source/adc_ctrl_if.sv */
// ****************************************
// control settings from the register bank
// to the conversion timer and the lane capture block
// ****************************************

`timescale 1ns/1ps

`include "adc_if_config.svh"

interface adc_ctrl_if;

  // conversions run while this is high
  logic                      enable;
  // high selects lanes a and b, low selects lane a only
  logic                      two_lanes;
  // conversion period in system clock cycles, already clamped
  logic [15:0]               period;
  // number of bit clocks per conversion, derived from two_lanes
  logic [`ADC_GATE_BITS-1:0] gate_len;

  // the register bank owns every control signal
  modport regs (output enable, output two_lanes, output period, output gate_len);

  // the timer only needs the cadence and the window length
  modport timer (input enable, input period, input gate_len);

  // the capture block only needs the lane layout
  modport capture (input two_lanes);

endinterface

/* source/adc_if_pkg.sv */
// ****************************************
// types shared by the ADC front end blocks
// import into a module header where the capture word or register map is used
// ****************************************

`include "adc_if_config.svh"

package adc_if_pkg;

  // the two lane parts of a sample in two-lane mode
  // lane a carries the upper bits and lane b the lower bits
  typedef struct packed {
    logic [`ADC_LANE_BITS-1:0] lane_a;
    logic [`ADC_LANE_BITS-1:0] lane_b;
  } adc_lanes_t;

  // one capture word seen two ways
  // word is the full shift register used in one-lane mode,
  // lanes splits the same bits into two independent 9-bit shifters
  typedef union packed {
    logic [`ADC_RESOLUTION-1:0] word;
    adc_lanes_t                 lanes;
  } adc_word_u;

  // register offsets as seen by the APB decoder
  typedef enum logic [3:0] {
    ADDR_CTRL   = `REG_CTRL,
    ADDR_PERIOD = `REG_PERIOD,
    ADDR_SAMPLE = `REG_SAMPLE,
    ADDR_STATUS = `REG_STATUS
  } adc_reg_e;

endpackage

/* source/adc_if_config.svh */
// ****************************************
// shared constants for the SAR ADC front end
// include wherever widths, timing limits or register offsets are needed
// ****************************************

`ifndef ADC_IF_CONFIG_SVH
`define ADC_IF_CONFIG_SVH

// sample width delivered by the converter
`define ADC_RESOLUTION 18

// bits carried by each lane when both lanes are active
`define ADC_LANE_BITS 9

// width of the gate length field, wide enough to hold ADC_RESOLUTION
`define ADC_GATE_BITS $clog2(`ADC_RESOLUTION + 1)

// shortest legal conversion period in system clock cycles
// anything smaller written to the period register is raised to this
`define ADC_MIN_PERIOD 24

// cycles between the cnv pulse and the first gated bit clock
`define ADC_CONV_DELAY 2

// APB byte offsets of the register bank
`define REG_CTRL   4'h0
`define REG_PERIOD 4'h4
`define REG_SAMPLE 4'h8
`define REG_STATUS 4'hC

`endif
